// File: build.f
+incdir+sim
logic/rv_exec_pkg.sv
logic/reg_file.sv
logic/int_alu.sv
logic/inst_decoder.sv
logic/execute_stage.sv
logic/exec_core.sv
sim/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module exec_core_tb -f build.f -o exec_core_tb
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/exec_core_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "Pass line not found in $LOG"
exit 1

// File: sim/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Instruction encoders, ISA field order
function automatic rv_exec_pkg::word_t enc_reg(input logic [2:0] f3, input logic [6:0] f7,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
   return {f7, rs2, rs1, f3, rd, rv_exec_pkg::OPC_OP};
endfunction

function automatic rv_exec_pkg::word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_exec_pkg::word_t enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
   return {imm, rd, opc};
endfunction

function automatic rv_exec_pkg::word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
   return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_exec_pkg::OPC_BRANCH};
endfunction

function automatic rv_exec_pkg::word_t enc_j(input logic [4:0] rd, input logic [20:0] off);
   return {off[20], off[10:1], off[11], off[19:12], rd, rv_exec_pkg::OPC_JAL};
endfunction

// Integer ops by funct3, alt picks SUB or SRA
function automatic rv_exec_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                               input rv_exec_pkg::word_t a,
                                               input rv_exec_pkg::word_t b);
   case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
   endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input rv_exec_pkg::word_t a,
                                    input rv_exec_pkg::word_t b);
   case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
   endcase
endfunction

// Expected result of one instruction, then the shadow register update
function automatic rv_exec_pkg::result_t model_step(input rv_exec_pkg::word_t inst,
                                                    input rv_exec_pkg::word_t pc);
   rv_exec_pkg::result_t r;
   rv_exec_pkg::word_t   a;
   rv_exec_pkg::word_t   b;
   rv_exec_pkg::word_t   imm_i;
   rv_exec_pkg::word_t   imm_u;
   rv_exec_pkg::word_t   imm_b;
   rv_exec_pkg::word_t   imm_j;
   logic [2:0]           f3;
   logic                 f7_ok;
   logic                 f7_checked;
   f3    = inst[14:12];
   a     = shadow[inst[19:15]];
   b     = shadow[inst[24:20]];
   imm_i = {{20{inst[31]}}, inst[31:20]};
   imm_u = {inst[31:12], 12'b0};
   imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
   f7_ok = (inst[31:25] == 7'h00) || (inst[31:25] == 7'h20);
   f7_checked = (f3 == 3'd1) || (f3 == 3'd5);
   r       = '0;
   r.rd    = inst[11:7];
   r.wb_en = 1'b1;
   case (inst[6:0])
      rv_exec_pkg::OPC_OP_IMM: begin
         r.invalid = f7_checked && !f7_ok;
         r.value   = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
      end
      rv_exec_pkg::OPC_OP: begin
         r.invalid = (f7_checked || f3 == 3'd0) && !f7_ok;
         r.value   = alu_ref(f3, inst[30], a, b);
      end
      rv_exec_pkg::OPC_LUI:   r.value = imm_u;
      rv_exec_pkg::OPC_AUIPC: r.value = pc + imm_u;
      rv_exec_pkg::OPC_JAL: begin
         r.value     = pc + 32'd4;
         r.pc_change = 1'b1;
         r.new_pc    = pc + imm_j;
      end
      rv_exec_pkg::OPC_JALR: begin
         r.value     = pc + 32'd4;
         r.pc_change = 1'b1;
         r.new_pc    = (a + imm_i) & ~32'd1;
      end
      rv_exec_pkg::OPC_BRANCH: begin
         r.wb_en     = 1'b0;
         r.pc_change = branch_ref(f3, a, b);
         r.new_pc    = pc + imm_b;
      end
      default: r.invalid = 1'b1;
   endcase
   if (r.invalid) begin
      r.wb_en = 1'b0;
   end
   if (r.wb_en && r.rd != 5'd0) begin
      shadow[r.rd] = r.value;
   end
   return r;
endfunction

`endif

// File: sim/exec_core_tb.sv
`default_nettype none

module exec_core_tb;

   localparam int          CLK_PERIOD = 40;
   localparam int          RST_CYCLES = 8;
   localparam int          TBL_MAX    = 128;
   localparam logic [15:0] LFSR_SEED  = 16'd8921;

   logic                 i_clk          = 1'b0;
   logic                 i_rst          = 1'b1;
   rv_exec_pkg::word_t   i_inst         = '0;
   rv_exec_pkg::word_t   i_pc           = '0;
   logic                 i_inst_valid   = 1'b0;
   logic                 i_result_ready = 1'b1;
   logic                 o_inst_ready;
   rv_exec_pkg::result_t o_result;
   logic                 o_result_valid;

   rv_exec_pkg::word_t   tbl_inst   [TBL_MAX];
   rv_exec_pkg::word_t   tbl_pc     [TBL_MAX];
   rv_exec_pkg::result_t tbl_exp    [TBL_MAX];
   int                   accept_cyc [TBL_MAX];
   int                   tbl_len  = 0;
   int                   prog_len = 0; // First pass runs without back-pressure
   logic                 built    = 1'b0;
   rv_exec_pkg::word_t   shadow [32];
   rv_exec_pkg::word_t   next_pc;

   int                   cycle     = 0;
   int                   recv_idx  = 0;
   int                   send_idx  = 0;
   int                   errors    = 0;
   int                   checks    = 0;
   int                   last_take = 0;
   logic                 held      = 1'b0;
   logic                 out_of_rst = 1'b0;
   rv_exec_pkg::result_t held_res;
   logic [15:0]          lfsr = LFSR_SEED;

   `include "exec_ref_model.svh"

   exec_core DUT (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_inst         (i_inst),
      .i_pc           (i_pc),
      .i_inst_valid   (i_inst_valid),
      .o_inst_ready   (o_inst_ready),
      .o_result       (o_result),
      .o_result_valid (o_result_valid),
      .i_result_ready (i_result_ready)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   always @(posedge i_clk) cycle <= cycle + 1;

   // Galois form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic add_inst(input rv_exec_pkg::word_t inst);
      tbl_inst[tbl_len] = inst;
      tbl_pc[tbl_len]   = next_pc;
      tbl_exp[tbl_len]  = model_step(inst, next_pc);
      next_pc += 32'd4;
      tbl_len++;
   endtask

   task automatic build_program();
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'h123));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'hFFB)); // -5
      add_inst(enc_reg(3'd0, 7'h00, 5'd3, 5'd1, 5'd2));
      add_inst(enc_reg(3'd0, 7'h20, 5'd4, 5'd1, 5'd2));   // SUB
      add_inst(enc_reg(3'd2, 7'h00, 5'd5, 5'd2, 5'd1));
      add_inst(enc_reg(3'd3, 7'h00, 5'd6, 5'd2, 5'd1));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd2, 5'd7, 5'd2, 12'hFFC));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd3, 5'd8, 5'd1, 12'hFFF));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd4, 5'd9, 5'd1, 12'h0F0));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd6, 5'd10, 5'd2, 12'h00F));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd7, 5'd11, 5'd2, 12'h7F0));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd1, 5'd12, 5'd1, 12'd20));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd5, 5'd13, 5'd2, 12'h004));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd5, 5'd14, 5'd2, 12'h404)); // SRAI
      add_inst(enc_reg(3'd1, 7'h00, 5'd15, 5'd1, 5'd1));
      add_inst(enc_reg(3'd5, 7'h00, 5'd16, 5'd2, 5'd7));
      add_inst(enc_reg(3'd5, 7'h20, 5'd17, 5'd2, 5'd1));
      add_inst(enc_reg(3'd4, 7'h00, 5'd18, 5'd1, 5'd2));
      add_inst(enc_reg(3'd6, 7'h00, 5'd19, 5'd4, 5'd2));
      add_inst(enc_reg(3'd7, 7'h00, 5'd20, 5'd2, 5'd9));
      add_inst(enc_u(rv_exec_pkg::OPC_LUI, 5'd21, 20'hABCDE));
      add_inst(enc_u(rv_exec_pkg::OPC_AUIPC, 5'd22, 20'h12345));
      add_inst(enc_j(5'd23, 21'h000040));
      add_inst(enc_j(5'd0, 21'h1FFFF8));                 // Link into x0
      add_inst(enc_i(rv_exec_pkg::OPC_JALR, 3'd0, 5'd24, 5'd1, 12'h010));
      add_inst(enc_reg(3'd6, 7'h00, 5'd25, 5'd0, 5'd23));
      add_inst(enc_reg(3'd0, 7'h00, 5'd26, 5'd0, 5'd0));
      add_inst(enc_b(3'd0, 5'd1, 5'd1, 13'h0010));
      add_inst(enc_b(3'd0, 5'd1, 5'd2, 13'h0010));
      add_inst(enc_b(3'd1, 5'd1, 5'd2, 13'h1FE0));
      add_inst(enc_b(3'd4, 5'd2, 5'd1, 13'h0008));
      add_inst(enc_b(3'd4, 5'd1, 5'd2, 13'h0008));
      add_inst(enc_b(3'd5, 5'd1, 5'd2, 13'h1FFC));
      add_inst(enc_b(3'd5, 5'd2, 5'd1, 13'h000C));
      add_inst(enc_b(3'd5, 5'd1, 5'd1, 13'h0014));
      add_inst(enc_b(3'd6, 5'd1, 5'd2, 13'h0018));
      add_inst(enc_b(3'd6, 5'd2, 5'd1, 13'h0018));
      add_inst(enc_b(3'd7, 5'd2, 5'd1, 13'h1FC0));
      add_inst(enc_b(3'd7, 5'd1, 5'd2, 13'h1FC0));
      add_inst(enc_b(3'd7, 5'd2, 5'd2, 13'h0020));
      add_inst(enc_i(7'b0000011, 3'd2, 5'd1, 5'd0, 12'h004)); // Load opcode
      add_inst(enc_reg(3'd0, 7'h01, 5'd1, 5'd2, 5'd2));
      add_inst(enc_i(rv_exec_pkg::OPC_OP_IMM, 3'd5, 5'd1, 5'd2, 12'h203));
      add_inst(enc_reg(3'd0, 7'h00, 5'd27, 5'd1, 5'd0)); // x1 untouched
   endtask

   task automatic build_table();
      for (int i = 0; i < 32; i++) begin
         shadow[i] = '0;
      end
      next_pc = 32'h0000_0100;
      build_program();
      prog_len = tbl_len;
      build_program();
   endtask

   task automatic report_value(input int idx, input string name, input rv_exec_pkg::word_t got,
                               input rv_exec_pkg::word_t exp);
      errors++;
      $display("ERROR entry %0d: %s = %h, expected %h", idx, name, got, exp);
   endtask

   task automatic check_result(input int idx);
      rv_exec_pkg::result_t exp;
      checks++;
      assert (idx < tbl_len) else begin
         errors++;
         $display("A result arrived after every table entry was already matched");
      end
      if (idx < tbl_len) begin
         exp = tbl_exp[idx];
         assert (o_result.invalid == exp.invalid)
            else report_value(idx, "o_result.invalid", 32'(o_result.invalid), 32'(exp.invalid));
         assert (o_result.wb_en == exp.wb_en)
            else report_value(idx, "o_result.wb_en", 32'(o_result.wb_en), 32'(exp.wb_en));
         assert (!exp.wb_en || o_result.rd == exp.rd)
            else report_value(idx, "o_result.rd", 32'(o_result.rd), 32'(exp.rd));
         assert (!exp.wb_en || o_result.value == exp.value)
            else report_value(idx, "o_result.value", o_result.value, exp.value);
         assert (o_result.pc_change == exp.pc_change)
            else report_value(idx, "o_result.pc_change", 32'(o_result.pc_change),
                              32'(exp.pc_change));
         assert (!exp.pc_change || o_result.new_pc == exp.new_pc)
            else report_value(idx, "o_result.new_pc", o_result.new_pc, exp.new_pc);
         if (idx < prog_len) begin
            assert (cycle - accept_cyc[idx] == 2) else begin
               errors++;
               $display("Entry %0d came %0d cycles after it was accepted instead of 2",
                        idx, cycle - accept_cyc[idx]);
            end
            assert (idx == 0 || cycle == last_take + 1) else begin
               errors++;
               $display("Entry %0d did not follow the previous result on the next cycle", idx);
            end
         end
      end
   endtask

   // Collects results in order, checks holding, drives ready
   always @(posedge i_clk) begin
      if (i_rst) begin
         i_result_ready <= 1'b1;
      end else begin
         if (!out_of_rst) begin
            out_of_rst = 1'b1;
            assert (!o_result_valid && o_inst_ready) else begin
               errors++;
               $display("Handshake outputs are wrong right after reset");
            end
         end
         if (held) begin
            assert (o_result_valid) else begin
               errors++;
               $display("Result valid dropped before entry %0d was taken", recv_idx);
            end
            assert (o_result == held_res) else begin
               errors++;
               $display("ERROR entry %0d: o_result = %h, expected %h",
                        recv_idx, o_result, held_res);
            end
         end
         held     = o_result_valid && !i_result_ready;
         held_res = o_result;
         if (o_result_valid && i_result_ready) begin
            check_result(recv_idx);
            last_take = cycle;
            recv_idx++;
         end
         if (recv_idx >= prog_len) begin
            i_result_ready <= lfsr[0];
            lfsr = lfsr_step(lfsr);
         end
      end
   end

   initial begin
      build_table();
      built = 1'b1;
      repeat (RST_CYCLES) @(posedge i_clk);
      i_rst <= 1'b0;
      while (send_idx < tbl_len) begin
         i_inst       <= tbl_inst[send_idx];
         i_pc         <= tbl_pc[send_idx];
         i_inst_valid <= 1'b1;
         @(posedge i_clk);
         if (o_inst_ready) begin
            accept_cyc[send_idx] = cycle;
            send_idx++;
         end
      end
      i_inst_valid <= 1'b0;
      wait (recv_idx == tbl_len);
      repeat (4) @(posedge i_clk); // Room for a stray extra result
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      wait (built);
      #((tbl_len * 20 + RST_CYCLES) * CLK_PERIOD);
      $display("Timed out with %0d of %0d results received", recv_idx, tbl_len);
      $display("checks %0d, errors %0d", checks, errors);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/exec_core.sv
`default_nettype none

module exec_core (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  rv_exec_pkg::word_t   i_inst,
   input  rv_exec_pkg::word_t   i_pc,
   input  logic                 i_inst_valid,
   output logic                 o_inst_ready,
   output rv_exec_pkg::result_t o_result,
   output logic                 o_result_valid,
   input  logic                 i_result_ready
);

   rv_exec_pkg::decoded_t dec;
   logic                  dec_valid;
   logic                  dec_ready;
   rv_exec_pkg::reg_idx_t rs1;
   rv_exec_pkg::reg_idx_t rs2;
   rv_exec_pkg::word_t    rs1_data;
   rv_exec_pkg::word_t    rs2_data;
   logic                  we;
   rv_exec_pkg::reg_idx_t rd;
   rv_exec_pkg::word_t    rd_data;

   inst_decoder u_decoder (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_inst       (i_inst),
      .i_pc         (i_pc),
      .i_inst_valid (i_inst_valid),
      .o_inst_ready (o_inst_ready),
      .o_dec        (dec),
      .o_dec_valid  (dec_valid),
      .i_dec_ready  (dec_ready)
   );

   execute_stage u_execute (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_dec          (dec),
      .i_dec_valid    (dec_valid),
      .o_dec_ready    (dec_ready),
      .o_rs1          (rs1),
      .o_rs2          (rs2),
      .i_rs1_data     (rs1_data),
      .i_rs2_data     (rs2_data),
      .o_we           (we),
      .o_rd           (rd),
      .o_rd_data      (rd_data),
      .o_result       (o_result),
      .o_result_valid (o_result_valid),
      .i_result_ready (i_result_ready)
   );

   reg_file u_regs (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (we),
      .i_rd       (rd),
      .i_rd_data  (rd_data)
   );

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`default_nettype none

module execute_stage (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  rv_exec_pkg::decoded_t i_dec,
   input  logic                  i_dec_valid,
   output logic                  o_dec_ready,
   output rv_exec_pkg::reg_idx_t o_rs1,
   output rv_exec_pkg::reg_idx_t o_rs2,
   input  rv_exec_pkg::word_t    i_rs1_data,
   input  rv_exec_pkg::word_t    i_rs2_data,
   output logic                  o_we,
   output rv_exec_pkg::reg_idx_t o_rd,
   output rv_exec_pkg::word_t    o_rd_data,
   output rv_exec_pkg::result_t  o_result,
   output logic                  o_result_valid,
   input  logic                  i_result_ready
);

   rv_exec_pkg::word_t   alu_a;
   rv_exec_pkg::word_t   alu_b;
   rv_exec_pkg::word_t   alu_y;
   rv_exec_pkg::word_t   link;
   logic                 taken;
   logic                 load;
   rv_exec_pkg::result_t res_next;
   rv_exec_pkg::result_t r_result;
   logic                 r_result_valid;

   assign o_rs1 = i_dec.rs1;
   assign o_rs2 = i_dec.rs2;

   assign alu_a = i_dec.use_pc_op1  ? i_dec.pc  : i_rs1_data;
   assign alu_b = i_dec.use_imm_op2 ? i_dec.imm : i_rs2_data;
   assign link  = i_dec.pc + 32'd4;

   int_alu u_alu (
      .i_op (i_dec.alu_op),
      .i_a  (alu_a),
      .i_b  (alu_b),
      .o_y  (alu_y)
   );

   // Compare on register values, the ALU forms the target
   always_comb begin
      case (i_dec.funct3)
         rv_exec_pkg::F3_BEQ:  taken = (i_rs1_data == i_rs2_data);
         rv_exec_pkg::F3_BNE:  taken = (i_rs1_data != i_rs2_data);
         rv_exec_pkg::F3_BLT:  taken = ($signed(i_rs1_data) <  $signed(i_rs2_data));
         rv_exec_pkg::F3_BGE:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
         rv_exec_pkg::F3_BLTU: taken = (i_rs1_data <  i_rs2_data);
         rv_exec_pkg::F3_BGEU: taken = (i_rs1_data >= i_rs2_data);
         default:              taken = 1'b0;
      endcase
   end

   always_comb begin
      res_next    = '0;
      res_next.rd = i_dec.rd;
      case (i_dec.kind)
         rv_exec_pkg::KIND_ALU: begin
            res_next.wb_en = 1'b1;
            res_next.value = alu_y;
         end
         rv_exec_pkg::KIND_LUI: begin
            res_next.wb_en = 1'b1;
            res_next.value = i_dec.imm;
         end
         rv_exec_pkg::KIND_JUMP_JAL: begin
            res_next.wb_en     = 1'b1;
            res_next.value     = link;
            res_next.pc_change = 1'b1;
            res_next.new_pc    = alu_y;
         end
         rv_exec_pkg::KIND_JUMP_JALR: begin
            res_next.wb_en     = 1'b1;
            res_next.value     = link;
            res_next.pc_change = 1'b1;
            res_next.new_pc    = {alu_y[31:1], 1'b0};
         end
         rv_exec_pkg::KIND_BRANCH: begin
            res_next.pc_change = taken;
            res_next.new_pc    = alu_y;
         end
         default: res_next.invalid = 1'b1;
      endcase
   end

   assign o_dec_ready = !r_result_valid || i_result_ready;
   assign load        = i_dec_valid && o_dec_ready;

   // Register write lands on the same edge as the result
   assign o_we      = load && res_next.wb_en;
   assign o_rd      = res_next.rd;
   assign o_rd_data = res_next.value;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_result_valid <= 1'b0;
      end else if (load) begin
         r_result_valid <= 1'b1;
      end else if (i_result_ready) begin
         r_result_valid <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         r_result <= res_next;
      end
   end

   assign o_result       = r_result;
   assign o_result_valid = r_result_valid;

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
`default_nettype none

module inst_decoder (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  rv_exec_pkg::word_t     i_inst,
   input  rv_exec_pkg::word_t     i_pc,
   input  logic                   i_inst_valid,
   output logic                   o_inst_ready,
   output rv_exec_pkg::decoded_t  o_dec,
   output logic                   o_dec_valid,
   input  logic                   i_dec_ready
);

   rv_exec_pkg::opcode_t  opcode;
   rv_exec_pkg::funct3_t  funct3;
   rv_exec_pkg::funct7_t  funct7;
   rv_exec_pkg::word_t    imm_i;
   rv_exec_pkg::word_t    imm_shamt;
   rv_exec_pkg::word_t    imm_u;
   rv_exec_pkg::word_t    imm_b;
   rv_exec_pkg::word_t    imm_j;
   logic                  f7_alt;
   logic                  f7_legal;
   logic                  is_shift;
   rv_exec_pkg::decoded_t dec_next;
   rv_exec_pkg::decoded_t r_dec;
   logic                  r_dec_valid;
   logic                  load;

   // Funct3 to ALU op, before funct7 picks SUB or SRA
   function automatic rv_exec_pkg::alu_op_t base_op(input rv_exec_pkg::funct3_t f3);
      case (f3)
         rv_exec_pkg::F3_SLL:  return rv_exec_pkg::ALU_SLL;
         rv_exec_pkg::F3_SLT:  return rv_exec_pkg::ALU_SLT;
         rv_exec_pkg::F3_SLTU: return rv_exec_pkg::ALU_SLTU;
         rv_exec_pkg::F3_XOR:  return rv_exec_pkg::ALU_XOR;
         rv_exec_pkg::F3_SRL:  return rv_exec_pkg::ALU_SRL;
         rv_exec_pkg::F3_OR:   return rv_exec_pkg::ALU_OR;
         rv_exec_pkg::F3_AND:  return rv_exec_pkg::ALU_AND;
         default:              return rv_exec_pkg::ALU_ADD;
      endcase
   endfunction

   assign opcode = i_inst[6:0];
   assign funct3 = i_inst[14:12];
   assign funct7 = i_inst[31:25];

   assign imm_i     = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_shamt = {27'b0, i_inst[24:20]};
   assign imm_u     = {i_inst[31:12], 12'b0};
   assign imm_b     = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                       i_inst[11:8], 1'b0};
   assign imm_j     = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                       i_inst[30:21], 1'b0};

   assign f7_alt   = (funct7 == rv_exec_pkg::FUNCT7_ALT);
   assign f7_legal = (funct7 == rv_exec_pkg::FUNCT7_BASE) || f7_alt;
   assign is_shift = (funct3 == rv_exec_pkg::F3_SLL) || (funct3 == rv_exec_pkg::F3_SRL);

   always_comb begin
      dec_next             = '0;
      dec_next.kind        = rv_exec_pkg::KIND_ALU;
      dec_next.alu_op      = rv_exec_pkg::ALU_ADD;
      dec_next.rs1         = i_inst[19:15];
      dec_next.rs2         = i_inst[24:20];
      dec_next.rd          = i_inst[11:7];
      dec_next.funct3      = funct3;
      dec_next.pc          = i_pc;
      case (opcode)
         rv_exec_pkg::OPC_OP_IMM: begin
            dec_next.use_imm_op2 = 1'b1;
            dec_next.alu_op      = base_op(funct3);
            dec_next.imm         = is_shift ? imm_shamt : imm_i;
            if (is_shift && !f7_legal) begin
               dec_next.kind = rv_exec_pkg::KIND_INVALID;
            end
            if (funct3 == rv_exec_pkg::F3_SRL && f7_alt) begin
               dec_next.alu_op = rv_exec_pkg::ALU_SRA;
            end
         end
         rv_exec_pkg::OPC_OP: begin
            dec_next.alu_op = base_op(funct3);
            if ((is_shift || funct3 == rv_exec_pkg::F3_ADD) && !f7_legal) begin
               dec_next.kind = rv_exec_pkg::KIND_INVALID;
            end
            if (f7_alt && funct3 == rv_exec_pkg::F3_ADD) begin
               dec_next.alu_op = rv_exec_pkg::ALU_SUB;
            end
            if (f7_alt && funct3 == rv_exec_pkg::F3_SRL) begin
               dec_next.alu_op = rv_exec_pkg::ALU_SRA;
            end
         end
         rv_exec_pkg::OPC_LUI: begin
            dec_next.kind = rv_exec_pkg::KIND_LUI;
            dec_next.imm  = imm_u;
         end
         rv_exec_pkg::OPC_AUIPC: begin
            dec_next.use_pc_op1  = 1'b1;
            dec_next.use_imm_op2 = 1'b1;
            dec_next.imm         = imm_u;
         end
         rv_exec_pkg::OPC_JAL: begin
            dec_next.kind        = rv_exec_pkg::KIND_JUMP_JAL;
            dec_next.use_pc_op1  = 1'b1;
            dec_next.use_imm_op2 = 1'b1;
            dec_next.imm         = imm_j;
         end
         rv_exec_pkg::OPC_JALR: begin
            dec_next.kind        = rv_exec_pkg::KIND_JUMP_JALR;
            dec_next.use_imm_op2 = 1'b1; // Target from rs1
            dec_next.imm         = imm_i;
         end
         rv_exec_pkg::OPC_BRANCH: begin
            dec_next.kind        = rv_exec_pkg::KIND_BRANCH;
            dec_next.use_pc_op1  = 1'b1;
            dec_next.use_imm_op2 = 1'b1;
            dec_next.imm         = imm_b;
         end
         default: dec_next.kind = rv_exec_pkg::KIND_INVALID;
      endcase
   end

   assign o_inst_ready = !r_dec_valid || i_dec_ready;
   assign load         = i_inst_valid && o_inst_ready;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_dec_valid <= 1'b0;
      end else if (load) begin
         r_dec_valid <= 1'b1;
      end else if (i_dec_ready) begin
         r_dec_valid <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         r_dec <= dec_next;
      end
   end

   assign o_dec       = r_dec;
   assign o_dec_valid = r_dec_valid;

endmodule

`default_nettype wire

// File: logic/int_alu.sv
`default_nettype none

module int_alu (
   input  rv_exec_pkg::alu_op_t i_op,
   input  rv_exec_pkg::word_t   i_a,
   input  rv_exec_pkg::word_t   i_b,
   output rv_exec_pkg::word_t   o_y
);

   logic [4:0] shamt;

   assign shamt = i_b[4:0];

   always_comb begin
      case (i_op)
         rv_exec_pkg::ALU_ADD:  o_y = i_a + i_b;
         rv_exec_pkg::ALU_SUB:  o_y = i_a - i_b;
         rv_exec_pkg::ALU_SLT:  o_y = {31'b0, $signed(i_a) < $signed(i_b)};
         rv_exec_pkg::ALU_SLTU: o_y = {31'b0, i_a < i_b};
         rv_exec_pkg::ALU_XOR:  o_y = i_a ^ i_b;
         rv_exec_pkg::ALU_OR:   o_y = i_a | i_b;
         rv_exec_pkg::ALU_AND:  o_y = i_a & i_b;
         rv_exec_pkg::ALU_SLL:  o_y = i_a << shamt;
         rv_exec_pkg::ALU_SRL:  o_y = i_a >> shamt;
         rv_exec_pkg::ALU_SRA:  o_y = $unsigned($signed(i_a) >>> shamt);
         default:               o_y = '0; // Unused codes
      endcase
   end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

module reg_file (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  rv_exec_pkg::reg_idx_t i_rs1,
   input  rv_exec_pkg::reg_idx_t i_rs2,
   output rv_exec_pkg::word_t    o_rs1_data,
   output rv_exec_pkg::word_t    o_rs2_data,
   input  logic                  i_we,
   input  rv_exec_pkg::reg_idx_t i_rd,
   input  rv_exec_pkg::word_t    i_rd_data
);

   rv_exec_pkg::word_t regs [rv_exec_pkg::NUM_REGS];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && i_rd != '0) begin // x0 stays zero
         regs[i_rd] <= i_rd_data;
      end
   end

   assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
   assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

   localparam int unsigned NUM_REGS = 32;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [2:0]  inst_kind_t;
   typedef logic [6:0]  opcode_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;

   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_AUIPC  = 7'b0010111;
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_JALR   = 7'b1100111;
   localparam opcode_t OPC_BRANCH = 7'b1100011;

   // Branch conditions
   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;
   localparam funct3_t F3_BLT  = 3'b100;
   localparam funct3_t F3_BGE  = 3'b101;
   localparam funct3_t F3_BLTU = 3'b110;
   localparam funct3_t F3_BGEU = 3'b111;

   // ALU functions, shared by OP and OP_IMM
   localparam funct3_t F3_ADD  = 3'b000;
   localparam funct3_t F3_SLL  = 3'b001;
   localparam funct3_t F3_SLT  = 3'b010;
   localparam funct3_t F3_SLTU = 3'b011;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_SRL  = 3'b101;
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;

   localparam funct7_t FUNCT7_BASE = 7'b0000000;
   localparam funct7_t FUNCT7_ALT  = 7'b0100000; // SUB and SRA

   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_SLT  = 4'd2;
   localparam alu_op_t ALU_SLTU = 4'd3;
   localparam alu_op_t ALU_XOR  = 4'd4;
   localparam alu_op_t ALU_OR   = 4'd5;
   localparam alu_op_t ALU_AND  = 4'd6;
   localparam alu_op_t ALU_SLL  = 4'd7;
   localparam alu_op_t ALU_SRL  = 4'd8;
   localparam alu_op_t ALU_SRA  = 4'd9;

   localparam inst_kind_t KIND_ALU       = 3'd0; // OP, OP_IMM and AUIPC
   localparam inst_kind_t KIND_LUI       = 3'd1;
   localparam inst_kind_t KIND_JUMP_JAL  = 3'd2;
   localparam inst_kind_t KIND_JUMP_JALR = 3'd3;
   localparam inst_kind_t KIND_BRANCH    = 3'd4;
   localparam inst_kind_t KIND_INVALID   = 3'd5;

   typedef struct packed {
      inst_kind_t kind;
      alu_op_t    alu_op;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      reg_idx_t   rd;
      word_t      imm;
      logic       use_pc_op1;
      logic       use_imm_op2;
      funct3_t    funct3;
      word_t      pc;
   } decoded_t;

   typedef struct packed {
      logic     wb_en;
      reg_idx_t rd;
      word_t    value;
      logic     pc_change;
      word_t    new_pc;
      logic     invalid;
   } result_t;

endpackage

`default_nettype wire
